/* Makefile */
# Verilator build and run for the arcade glue testbench

VERILATOR ?= verilator
TOP       ?= arcade_glue_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_TEXT ?= Result: FAILED

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	@$(SIM) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG); then \
	  echo "test failed, see $(LOG)"; exit 1; \
	fi; \
	exit $$rc

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+source
source/arcade_pkg.sv
source/bridge_settings.sv
source/control_sync.sv
source/ce_divider.sv
source/video_out.sv
source/arcade_glue_top.sv
test/arcade_glue_props.sv
test/arcade_glue_tb.sv

/* source/arcade_consts.svh */
/*
  arcade glue constants
  bridge setting addresses, enable dividers, key synchronizer
  depth and controller key bit positions
*/

`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// bridge settings, byte addresses
`define TEST_MODE_ADDR 32'h0000_0000
// dip 1 at base, dip 8 at base + 7 steps
`define DIP_ADDR_BASE  32'h0000_0010
`define DIP_ADDR_STEP  32'h0000_0010

// clock enable dividers, in clk_74a cycles
`define CPU_CE_DIV     10
`define SOUND_CE_DIV   56

// flops in the key synchronizer
`define SYNC_STAGES    3

// controller key bitmap positions
`define KEY_UP         0
`define KEY_DOWN       1
`define KEY_LEFT       2
`define KEY_RIGHT      3
`define KEY_A          4
`define KEY_X          6
`define KEY_SELECT     14
`define KEY_START      15

`endif

/* source/arcade_glue_top.sv */
/*
  arcade glue top
  bridge settings, controller ports, clock enables and video stage
*/

`timescale 1ns/1ns
`default_nettype none

`include "arcade_consts.svh"

module arcade_glue_top (
  input  wire                           clk_74a,
  input  wire                           rst_n,
  // bridge and data slot strobes
  input  wire                           bridge_wr,
  input  wire arcade_pkg::bridge_addr_t bridge_addr,
  input  wire arcade_pkg::bridge_data_t bridge_wr_data,
  input  wire                           dataslot_requestwrite,
  input  wire                           dataslot_allcomplete,
  // controller
  input  wire arcade_pkg::key_bits_t    cont1_key,
  // video from the core
  input  wire                           hblank,
  input  wire                           vblank,
  input  wire                           hsync,
  input  wire                           vsync,
  input  wire arcade_pkg::rgb_t         rgb_in,
  // board side
  output logic                          test_mode,
  output arcade_pkg::dip_bits_t         dip_switch,
  output logic                          rom_init,
  output arcade_pkg::port_byte_t        ip1710,
  output arcade_pkg::port_byte_t        ip4740,
  output logic                          cpu_ce,
  output logic                          sound_ce,
  // scaler side
  output logic                          video_de,
  output logic                          video_hs,
  output logic                          video_vs,
  output arcade_pkg::rgb_t              video_rgb
);

  //////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////

  bridge_settings bridge_settings_inst (
    .clk_74a               (clk_74a),
    .rst_n                 (rst_n),
    .bridge_wr             (bridge_wr),
    .bridge_addr           (bridge_addr),
    .bridge_wr_data        (bridge_wr_data),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .test_mode             (test_mode),
    .dip_switch            (dip_switch),
    .rom_init              (rom_init)
  );

  // test_mode also feeds port 1710
  control_sync control_sync_inst (
    .clk_74a   (clk_74a),
    .rst_n     (rst_n),
    .cont1_key (cont1_key),
    .test_mode (test_mode),
    .ip1710    (ip1710),
    .ip4740    (ip4740)
  );

  //////////////////////////////////////////////////
  // clock enables
  //////////////////////////////////////////////////

  ce_divider #(.DIVIDE(`CPU_CE_DIV)) cpu_ce_gen (
    .clk_74a (clk_74a),
    .rst_n   (rst_n),
    .ce      (cpu_ce)
  );

  ce_divider #(.DIVIDE(`SOUND_CE_DIV)) sound_ce_gen (
    .clk_74a (clk_74a),
    .rst_n   (rst_n),
    .ce      (sound_ce)
  );

  //////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////

  video_out video_out_inst (
    .clk_74a   (clk_74a),
    .rst_n     (rst_n),
    .hblank    (hblank),
    .vblank    (vblank),
    .hsync     (hsync),
    .vsync     (vsync),
    .rgb_in    (rgb_in),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs),
    .video_rgb (video_rgb)
  );

endmodule

`default_nettype wire

/* source/arcade_pkg.sv */
/*
  arcade glue types
  vector typedefs for bridge, controller, DIP and video signals
*/

`default_nettype none

package arcade_pkg;

  // bridge byte address
  typedef logic [31:0] bridge_addr_t;
  // bridge write data word
  typedef logic [31:0] bridge_data_t;

  // controller key bitmap, one bit per button
  typedef logic [15:0] key_bits_t;

  // one input port byte of the board
  typedef logic [7:0]  port_byte_t;

  // dip 1 in bit 7, dip 8 in bit 0
  typedef logic [7:0]  dip_bits_t;

  // red [23:16], green [15:8], blue [7:0]
  typedef logic [23:0] rgb_t;

endpackage

`default_nettype wire

/* source/bridge_settings.sv */
/*
  bridge settings
  test-mode switch and DIP bank written by the host bridge,
  plus the ROM download level from the data-slot strobes
*/

`timescale 1ns/1ns
`default_nettype none

`include "arcade_consts.svh"

module bridge_settings (
  input  wire                      clk_74a,
  input  wire                      rst_n,
  input  wire                      bridge_wr,
  input  wire arcade_pkg::bridge_addr_t bridge_addr,
  input  wire arcade_pkg::bridge_data_t bridge_wr_data,
  input  wire                      dataslot_requestwrite,
  input  wire                      dataslot_allcomplete,
  output logic                     test_mode,
  output arcade_pkg::dip_bits_t    dip_switch,
  output logic                     rom_init
);

  import arcade_pkg::*;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  // one-hot hit per dip, same bit order as dip_switch
  dip_bits_t dip_hit;
  logic      test_hit;

  assign test_hit = (bridge_addr == bridge_addr_t'(`TEST_MODE_ADDR));

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      // dip 1 lands in the top bit
      dip_hit[7 - i] =
        (bridge_addr == bridge_addr_t'(`DIP_ADDR_BASE + i * `DIP_ADDR_STEP));
    end
  end

  //////////////////////////////////////////////////
  // setting registers
  //////////////////////////////////////////////////

  // only bit 0 of the write word is kept
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      test_mode <= 1'b0;
    end else if (bridge_wr && test_hit) begin
      test_mode <= bridge_wr_data[0];
    end
  end

  // hit bits take the new value, the rest hold
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      dip_switch <= '0;
    end else if (bridge_wr) begin
      dip_switch <= (dip_switch & ~dip_hit) |
                    ({8{bridge_wr_data[0]}} & dip_hit);
    end
  end

  //////////////////////////////////////////////////
  // rom download level
  //////////////////////////////////////////////////

  // request wins when both strobes share a cycle
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      rom_init <= 1'b0;
    end else if (dataslot_requestwrite) begin
      rom_init <= 1'b1;
    end else if (dataslot_allcomplete) begin
      rom_init <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/ce_divider.sv */
/*
  clock enable divider
  one-cycle enable every DIVIDE clk_74a cycles
*/

`timescale 1ns/1ns
`default_nettype none

module ce_divider #(
  parameter int DIVIDE = 10
) (
  input  wire  clk_74a,
  input  wire  rst_n,
  output logic ce
);

  // counter just wide enough for DIVIDE - 1
  localparam int CNT_W = (DIVIDE > 2) ? $clog2(DIVIDE) : 1;

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIVIDE - 1);

  logic [CNT_W-1:0] cnt;

  //////////////////////////////////////////////////
  // wrapping counter and enable
  //////////////////////////////////////////////////

  // enable follows the cycle the counter sits at its last value
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
      ce  <= 1'b0;
    end else if (cnt == CNT_LAST) begin
      cnt <= '0;
      ce  <= 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
      ce  <= 1'b0;
    end
  end

  // first pulse lands DIVIDE cycles after reset release

endmodule

`default_nettype wire

/* source/control_sync.sv */
/*
  controller synchronizer
  brings the player-one key bitmap into clk_74a and maps it
  onto the board's two input port bytes
*/

`timescale 1ns/1ns
`default_nettype none

`include "arcade_consts.svh"

module control_sync (
  input  wire                        clk_74a,
  input  wire                        rst_n,
  input  wire arcade_pkg::key_bits_t cont1_key,
  input  wire                        test_mode,
  output arcade_pkg::port_byte_t     ip1710,
  output arcade_pkg::port_byte_t     ip4740
);

  import arcade_pkg::*;

  //////////////////////////////////////////////////
  // key synchronizer
  //////////////////////////////////////////////////

  // stage 0 samples the asynchronous keys
  key_bits_t key_sync [`SYNC_STAGES];
  key_bits_t key_q;

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `SYNC_STAGES; s++) begin
        key_sync[s] <= '0;
      end
    end else begin
      key_sync[0] <= cont1_key;
      for (int s = 1; s < `SYNC_STAGES; s++) begin
        key_sync[s] <= key_sync[s - 1];
      end
    end
  end

  // last stage feeds the mapping
  assign key_q = key_sync[`SYNC_STAGES - 1];

  //////////////////////////////////////////////////
  // port mapping
  //////////////////////////////////////////////////

  // test switch is active low on the board
  assign ip1710 = {
    key_q[`KEY_A],       // test 1
    ~test_mode,          // test 2
    2'b00,
    key_q[`KEY_SELECT],  // coin 1
    1'b0,                // coin 2, not mapped
    key_q[`KEY_X],       // player 2 start
    key_q[`KEY_START]    // player 1 start
  };

  // joystick directions in the low nibble
  assign ip4740 = {
    4'b0000,
    key_q[`KEY_LEFT],
    key_q[`KEY_RIGHT],
    key_q[`KEY_UP],
    key_q[`KEY_DOWN]
  };

endmodule

`default_nettype wire

/* source/video_out.sv */
/*
  video output stage
  registered data enable, colour held outside the active area
  and one-cycle pulses on rising sync edges
*/

`timescale 1ns/1ns
`default_nettype none

module video_out (
  input  wire                   clk_74a,
  input  wire                   rst_n,
  input  wire                   hblank,
  input  wire                   vblank,
  input  wire                   hsync,
  input  wire                   vsync,
  input  wire arcade_pkg::rgb_t rgb_in,
  output logic                  video_de,
  output logic                  video_hs,
  output logic                  video_vs,
  output arcade_pkg::rgb_t      video_rgb
);

  // active area, neither blank asserted
  logic active;
  // sync levels from the previous cycle
  logic hs_prev;
  logic vs_prev;

  assign active = ~(hblank | vblank);

  //////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      video_de <= active;
      // colour only loads in the active area
      if (active) begin
        video_rgb <= rgb_in;
      end
      // rising edge detect, one cycle wide
      video_hs <= hsync & ~hs_prev;
      video_vs <= vsync & ~vs_prev;
      hs_prev  <= hsync;
      vs_prev  <= vsync;
    end
  end

endmodule

`default_nettype wire

/* test/arcade_glue_props.sv */
/*
  arcade glue properties
  enable and sync pulse widths, ROM download start
*/

`timescale 1ns/1ns
`default_nettype none

module arcade_glue_props (
  input wire clk_74a,
  input wire rst_n,
  input wire cpu_ce,
  input wire sound_ce,
  input wire video_hs,
  input wire rom_init,
  input wire dataslot_requestwrite
);

  // enables are single-cycle pulses
  cpu_ce_single : assert property (@(posedge clk_74a) disable iff (!rst_n)
    cpu_ce |=> !cpu_ce)
    else $error("cpu_ce high for two cycles in a row");

  sound_ce_single : assert property (@(posedge clk_74a) disable iff (!rst_n)
    sound_ce |=> !sound_ce)
    else $error("sound_ce high for two cycles in a row");

  // rising-edge pulse, never stretched
  hs_single : assert property (@(posedge clk_74a) disable iff (!rst_n)
    video_hs |=> !video_hs)
    else $error("video_hs high for two cycles in a row");

  // download level only set by a request strobe
  rom_init_rise : assert property (@(posedge clk_74a) disable iff (!rst_n)
    $rose(rom_init) |-> $past(dataslot_requestwrite))
    else $error("rom_init rose without dataslot_requestwrite");

endmodule

bind arcade_glue_top arcade_glue_props arcade_glue_props_inst (
  .clk_74a               (clk_74a),
  .rst_n                 (rst_n),
  .cpu_ce                (cpu_ce),
  .sound_ce              (sound_ce),
  .video_hs              (video_hs),
  .rom_init              (rom_init),
  .dataslot_requestwrite (dataslot_requestwrite)
);

`default_nettype wire

/* test/arcade_glue_tb.sv */
/*
  arcade glue testbench
  LFSR-driven bridge, controller, download and video stimulus,
  checked every cycle against a reference model
*/

`timescale 1ns/1ns
`default_nettype none

`include "arcade_consts.svh"

module arcade_glue_tb;

  import arcade_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int TEST_CYCLES  = 3000;
  // whole run plus some slack
  localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES) * 10 + 1000;

  // dut inputs
  logic         clk_74a;
  logic         rst_n;
  logic         bridge_wr;
  bridge_addr_t bridge_addr;
  bridge_data_t bridge_wr_data;
  logic         dataslot_requestwrite;
  logic         dataslot_allcomplete;
  key_bits_t    cont1_key;
  logic         hblank;
  logic         vblank;
  logic         hsync;
  logic         vsync;
  rgb_t         rgb_in;
  // dut outputs
  logic         test_mode;
  dip_bits_t    dip_switch;
  logic         rom_init;
  port_byte_t   ip1710;
  port_byte_t   ip4740;
  logic         cpu_ce;
  logic         sound_ce;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;
  rgb_t         video_rgb;

  // reference model state
  logic         tm_m;
  dip_bits_t    dip_m;
  logic         rom_m;
  key_bits_t    key_pipe [`SYNC_STAGES];
  int           cpu_cnt;
  int           snd_cnt;
  logic         cpu_ce_m;
  logic         snd_ce_m;
  logic         de_m;
  rgb_t         rgb_m;
  logic         hs_m;
  logic         vs_m;
  logic         hs_prev_m;
  logic         vs_prev_m;

  // bookkeeping
  logic [31:0]  lfsr = 32'h13c4;
  int           checks = 0;
  int           errors = 0;
  int           last_cpu = -1;
  int           last_snd = -1;

  arcade_glue_top arcade_glue_top_inst (
    .clk_74a               (clk_74a),
    .rst_n                 (rst_n),
    .bridge_wr             (bridge_wr),
    .bridge_addr           (bridge_addr),
    .bridge_wr_data        (bridge_wr_data),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .cont1_key             (cont1_key),
    .hblank                (hblank),
    .vblank                (vblank),
    .hsync                 (hsync),
    .vsync                 (vsync),
    .rgb_in                (rgb_in),
    .test_mode             (test_mode),
    .dip_switch            (dip_switch),
    .rom_init              (rom_init),
    .ip1710                (ip1710),
    .ip4740                (ip4740),
    .cpu_ce                (cpu_ce),
    .sound_ce              (sound_ce),
    .video_de              (video_de),
    .video_hs              (video_hs),
    .video_vs              (video_vs),
    .video_rgb             (video_rgb)
  );

  // 10 ns period
  always #5 clk_74a = ~clk_74a;

  //////////////////////////////////////////////////
  // random source
  //////////////////////////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic take_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // A, not test, 0, 0, coin 1, coin 2, p2 start, p1 start
  function automatic port_byte_t port_1710(input key_bits_t k, input logic tm);
    port_byte_t p;
    p = '0;
    p[7] = k[`KEY_A];
    p[6] = !tm;
    p[3] = k[`KEY_SELECT];
    p[1] = k[`KEY_X];
    p[0] = k[`KEY_START];
    return p;
  endfunction

  // directions only with the upper nibble zero
  function automatic port_byte_t port_4740(input key_bits_t k);
    port_byte_t p;
    p = '0;
    p[3] = k[`KEY_LEFT];
    p[2] = k[`KEY_RIGHT];
    p[1] = k[`KEY_UP];
    p[0] = k[`KEY_DOWN];
    return p;
  endfunction

  task automatic reset_model();
    tm_m = 1'b0;
    dip_m = '0;
    rom_m = 1'b0;
    for (int s = 0; s < `SYNC_STAGES; s++) begin
      key_pipe[s] = '0;
    end
    cpu_cnt = 0;
    snd_cnt = 0;
    cpu_ce_m = 1'b0;
    snd_ce_m = 1'b0;
    de_m = 1'b0;
    rgb_m = '0;
    hs_m = 1'b0;
    vs_m = 1'b0;
    hs_prev_m = 1'b0;
    vs_prev_m = 1'b0;
  endtask

  // one clock edge on the inputs held since the last drive
  task automatic step_model();
    logic active;
    if (bridge_wr) begin
      if (bridge_addr == `TEST_MODE_ADDR) begin
        tm_m = bridge_wr_data[0];
      end
      // dip n at base + (n - 1) steps with dip 1 in the top bit
      for (int n = 1; n <= 8; n++) begin
        if (bridge_addr == `DIP_ADDR_BASE + (n - 1) * `DIP_ADDR_STEP) begin
          dip_m[8 - n] = bridge_wr_data[0];
        end
      end
    end
    // request has priority
    if (dataslot_requestwrite) begin
      rom_m = 1'b1;
    end else if (dataslot_allcomplete) begin
      rom_m = 1'b0;
    end
    for (int s = `SYNC_STAGES - 1; s > 0; s--) begin
      key_pipe[s] = key_pipe[s - 1];
    end
    key_pipe[0] = cont1_key;
    // enables fire on the wrap of each counter
    cpu_ce_m = (cpu_cnt == `CPU_CE_DIV - 1);
    cpu_cnt = cpu_ce_m ? 0 : cpu_cnt + 1;
    snd_ce_m = (snd_cnt == `SOUND_CE_DIV - 1);
    snd_cnt = snd_ce_m ? 0 : snd_cnt + 1;
    active = !hblank && !vblank;
    de_m = active;
    if (active) begin
      rgb_m = rgb_in;
    end
    hs_m = hsync && !hs_prev_m;
    vs_m = vsync && !vs_prev_m;
    hs_prev_m = hsync;
    vs_prev_m = vsync;
  endtask

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // first pulse at cycle DIVIDE and then DIVIDE apart
  task automatic check_period(input string what, input int now, inout int last,
                              input int div);
    if (last < 0) begin
      check_value({what, " first pulse cycle"}, 32'(now), 32'(div));
    end else begin
      check_value({what, " pulse spacing"}, 32'(now - last), 32'(div));
    end
    last = now;
  endtask

  task automatic compare_outputs(input int cycle);
    check_value("test_mode", 32'(test_mode), 32'(tm_m));
    check_value("dip_switch", 32'(dip_switch), 32'(dip_m));
    check_value("rom_init", 32'(rom_init), 32'(rom_m));
    check_value("ip1710", 32'(ip1710),
                32'(port_1710(key_pipe[`SYNC_STAGES - 1], tm_m)));
    check_value("ip4740", 32'(ip4740), 32'(port_4740(key_pipe[`SYNC_STAGES - 1])));
    check_value("cpu_ce", 32'(cpu_ce), 32'(cpu_ce_m));
    check_value("sound_ce", 32'(sound_ce), 32'(snd_ce_m));
    check_value("video_de", 32'(video_de), 32'(de_m));
    check_value("video_rgb", 32'(video_rgb), 32'(rgb_m));
    check_value("video_hs", 32'(video_hs), 32'(hs_m));
    check_value("video_vs", 32'(video_vs), 32'(vs_m));
    if (cpu_ce) begin
      check_period("cpu_ce", cycle, last_cpu, `CPU_CE_DIV);
    end
    if (sound_ce) begin
      check_period("sound_ce", cycle, last_snd, `SOUND_CE_DIV);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic drive_inputs();
    int         sel;
    logic [2:0] slot;
    bridge_wr = take_bit();
    if (take_bit()) begin
      // one of the nine setting addresses
      sel = int'(take_bits(4) % 9);
      bridge_addr = (sel == 0) ? `TEST_MODE_ADDR :
                    `DIP_ADDR_BASE + (sel - 1) * `DIP_ADDR_STEP;
    end else begin
      // low addresses with some hits and near misses
      bridge_addr = bridge_addr_t'(take_bits(8));
      // upper bits set on about half of them
      if (take_bit()) begin
        bridge_addr[31:8] = 24'(take_bits(24));
      end
    end
    bridge_wr_data = take_bits(32);
    // slot 0 is a request, 1 a completion and 2 both at once
    slot = 3'(take_bits(3));
    dataslot_requestwrite = (slot == 3'd0) || (slot == 3'd2);
    dataslot_allcomplete = (slot == 3'd1) || (slot == 3'd2);
    cont1_key = key_bits_t'(take_bits(16));
    hblank = (take_bits(2) == 0);
    vblank = (take_bits(2) == 0);
    hsync = take_bit();
    vsync = take_bit();
    rgb_in = rgb_t'(take_bits(24));
  endtask

  initial begin
    clk_74a = 1'b0;
    rst_n = 1'b0;
    bridge_wr = 1'b0;
    bridge_addr = '0;
    bridge_wr_data = '0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete = 1'b0;
    cont1_key = '0;
    hblank = 1'b0;
    vblank = 1'b0;
    hsync = 1'b0;
    vsync = 1'b0;
    rgb_in = '0;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk_74a);
    #1;
    // reset values with the test bit alone in port 1710
    compare_outputs(0);
    check_value("ip1710 in reset", 32'(ip1710), 32'h40);
    rst_n = 1'b1;
    for (int cycle = 1; cycle <= TEST_CYCLES; cycle++) begin
      @(posedge clk_74a);
      step_model();
      #1;
      compare_outputs(cycle);
      drive_inputs();
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
